// ==== hdl/read_master_defs.svh ====
////////////////////////////////////////
// Read master defines
// Widths, burst size and in-flight limit
////////////////////////////////////////
`ifndef READ_MASTER_DEFS_SVH
`define READ_MASTER_DEFS_SVH

// Bus widths in bits
`define RM_ADDR_WIDTH      32
`define RM_DATA_WIDTH      32

// Width of the job length in bytes
`define RM_XFER_SIZE_WIDTH 32

// Words in one full burst, kept small for short runs
`define RM_BURST_BEATS     16

// Bursts allowed in flight before the address channel waits
`define RM_MAX_OUTSTANDING 4

// Room for every beat of every outstanding burst
`define RM_FIFO_DEPTH      64

`endif

// ==== hdl/axi_read_pkg.sv ====
////////////////////////////////////////
// Bus-side types of the read master
////////////////////////////////////////
`include "read_master_defs.svh"

package axi_read_pkg;

  // Byte address on the read-address channel
  typedef logic [`RM_ADDR_WIDTH-1:0] addr_t;

  // Burst length minus one, as carried on arlen
  typedef logic [7:0] arlen_t;

  // One data word of the read-data channel
  typedef logic [`RM_DATA_WIDTH-1:0] data_t;

  // Returned word with its end-of-burst flag
  // Data sits in the upper bits, last in bit 0
  typedef struct packed {
    data_t data;
    logic  last;
  } beat_t;

endpackage

// ==== hdl/xfer_pkg.sv ====
////////////////////////////////////////
// Job-side types of the read master
////////////////////////////////////////
`include "read_master_defs.svh"

package xfer_pkg;

  // Total words of a job minus one
  typedef logic [`RM_XFER_SIZE_WIDTH-$clog2(`RM_DATA_WIDTH/8)-1:0] word_count_t;

  // Full-burst steps, i.e. the word total without its in-burst index
  typedef logic [$bits(word_count_t)-$clog2(`RM_BURST_BEATS)-1:0] burst_count_t;

  // Beats in the final burst minus one
  typedef logic [$clog2(`RM_BURST_BEATS)-1:0] beat_index_t;

  // Free outstanding slots, counts 0 up to the limit
  typedef logic [$clog2(`RM_MAX_OUTSTANDING+1)-1:0] outstanding_t;

endpackage

// ==== hdl/read_job_if.sv ====
////////////////////////////////////////
// Decoded read job
// From request registers to issue and tracking
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

interface read_job_if;

  // One-cycle pulse, job fields are valid from here on
  logic                   launch;
  // Burst-aligned start address
  axi_read_pkg::addr_t    base_addr;
  // Bursts to go after the first one
  xfer_pkg::burst_count_t burst_steps;
  // arlen of the final burst
  xfer_pkg::beat_index_t  final_len;

  modport producer (output launch, base_addr, burst_steps, final_len);
  modport issuer   (input  launch, base_addr, burst_steps, final_len);
  modport tracker  (input  launch, burst_steps);

endinterface

// ==== hdl/read_request_regs.sv ====
////////////////////////////////////////
// Read request registers
// Captures a job at start and decodes it
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module read_request_regs (
  input  logic                           aclk,
  input  logic                           areset,
  input  logic                           start,
  input  axi_read_pkg::addr_t            addr_offset,
  input  logic [`RM_XFER_SIZE_WIDTH-1:0] xfer_size,
  read_job_if.producer                   job
);

  // Byte-in-word and word-in-burst index widths
  localparam int word_lsb  = $clog2(`RM_DATA_WIDTH/8);
  localparam int burst_lsb = $clog2(`RM_BURST_BEATS);
  // Offset bits inside one burst of bytes
  localparam axi_read_pkg::addr_t burst_mask =
    axi_read_pkg::addr_t'(`RM_BURST_BEATS * `RM_DATA_WIDTH / 8 - 1);

  xfer_pkg::word_count_t total_m1_r;
  axi_read_pkg::addr_t   base_r;
  logic                  start_d1;
  logic                  start_d2;

  // Job capture on start
  always_ff @(posedge aclk) begin
    if (start) begin
      // Partial word rounds up, so the truncated count is already length minus one
      if (xfer_size[word_lsb-1:0] != '0)
        total_m1_r <= xfer_size[`RM_XFER_SIZE_WIDTH-1:word_lsb];
      else
        total_m1_r <= xfer_size[`RM_XFER_SIZE_WIDTH-1:word_lsb] - 1'b1;
      // Align down to the burst boundary
      base_r <= addr_offset & ~burst_mask;
    end
  end

  // Two-stage start delay, gives the decode below a settled total
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start_d2 <= 1'b0;
    end else begin
      start_d1 <= start;
      start_d2 <= start_d1;
    end
  end

  assign job.launch      = start_d2;
  assign job.base_addr   = base_r;
  // Upper bits count full-burst steps, lower bits give the last arlen
  assign job.burst_steps = total_m1_r[$bits(xfer_pkg::word_count_t)-1:burst_lsb];
  assign job.final_len   = total_m1_r[burst_lsb-1:0];

endmodule

// ==== hdl/burst_counter.sv ====
////////////////////////////////////////
// Loadable up/down counter with zero flag
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module burst_counter #(
  parameter int               width       = 8,
  parameter logic [width-1:0] reset_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic [width-1:0] load_value,
  input  logic             incr,
  input  logic             decr,
  output logic [width-1:0] count,
  output logic             is_zero
);

  logic [width-1:0] count_r;

  // Load wins, incr with decr cancels out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count_r <= reset_value;
    end else if (load) begin
      count_r <= load_value;
    end else if (incr && !decr) begin
      count_r <= count_r + 1'b1;
    end else if (decr && !incr) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign count   = count_r;
  assign is_zero = (count_r == '0);

endmodule

// ==== hdl/ar_issue.sv ====
////////////////////////////////////////
// Read-address issue
// Steps bursts, limits those in flight
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module ar_issue (
  input  logic                   aclk,
  input  logic                   areset,
  read_job_if.issuer             job,
  input  logic                   credit_return,
  output logic                   arvalid,
  input  logic                   arready,
  output axi_read_pkg::addr_t    araddr,
  output axi_read_pkg::arlen_t   arlen
);

  logic                arvalid_r;
  logic                idle_r;
  axi_read_pkg::addr_t addr_r;
  logic                arxfer;
  logic                last_burst;
  logic                no_slots;

  assign arxfer = arvalid_r & arready;

  ////////////////////////////////////////
  // Burst and slot counters
  ////////////////////////////////////////
  // Remaining bursts, zero means the final one is up; held at zero once there
  burst_counter #(.width($bits(xfer_pkg::burst_count_t))) u_remaining (
    .aclk (aclk), .areset (areset),
    .load (job.launch), .load_value (job.burst_steps),
    .incr (1'b0), .decr (arxfer & ~last_burst),
    .count (), .is_zero (last_burst)
  );

  // Free slots, starts full and comes back as bursts leave the stream
  burst_counter #(
    .width       ($bits(xfer_pkg::outstanding_t)),
    .reset_value (xfer_pkg::outstanding_t'(`RM_MAX_OUTSTANDING))
  ) u_slots (
    .aclk (aclk), .areset (areset),
    .load (1'b0), .load_value ('0),
    .incr (credit_return), .decr (arxfer),
    .count (), .is_zero (no_slots)
  );

  ////////////////////////////////////////
  // Address channel
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle_r    <= 1'b1;
      arvalid_r <= 1'b0;
    end else begin
      if (job.launch)
        idle_r <= 1'b0;
      else if (arxfer && last_burst)
        idle_r <= 1'b1;
      // Raise when work and a slot exist, hold until accepted
      if (!idle_r && !no_slots && !arvalid_r)
        arvalid_r <= 1'b1;
      else if (arready)
        arvalid_r <= 1'b0;
    end
  end

  // One burst of bytes per accepted request
  always_ff @(posedge aclk) begin
    if (job.launch)
      addr_r <= job.base_addr;
    else if (arxfer)
      addr_r <= addr_r + axi_read_pkg::addr_t'(`RM_BURST_BEATS * `RM_DATA_WIDTH / 8);
  end

  assign arvalid = arvalid_r;
  assign araddr  = addr_r;
  assign arlen   = last_burst ? axi_read_pkg::arlen_t'(job.final_len)
                              : axi_read_pkg::arlen_t'(`RM_BURST_BEATS - 1);

endmodule

// ==== hdl/r_tracker.sv ====
////////////////////////////////////////
// Read-data tracker
// Counts finished bursts, flags job done
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module r_tracker (
  input  logic        aclk,
  input  logic        areset,
  read_job_if.tracker job,
  input  logic        rvalid,
  input  logic        rlast,
  output logic        done
);

  logic burst_end;
  logic final_burst;
  logic done_r;

  // Ready is tied high, so a valid last beat ends a burst
  assign burst_end = rvalid & rlast;

  // Bursts still to finish after the current one
  burst_counter #(.width($bits(xfer_pkg::burst_count_t))) u_remaining (
    .aclk (aclk), .areset (areset),
    .load (job.launch), .load_value (job.burst_steps),
    .incr (1'b0), .decr (burst_end & ~final_burst),
    .count (), .is_zero (final_burst)
  );

  // Single-cycle pulse after the last beat of the final burst
  always_ff @(posedge aclk) begin
    if (areset)
      done_r <= 1'b0;
    else
      done_r <= burst_end & final_burst;
  end

  assign done = done_r;

endmodule

// ==== hdl/beat_fifo.sv ====
////////////////////////////////////////
// Beat FIFO, show-ahead with a registered head
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module beat_fifo (
  input  logic                aclk,
  input  logic                areset,
  input  logic                push,
  input  axi_read_pkg::beat_t push_beat,
  input  logic                pop_ready,
  output logic                pop_valid,
  output axi_read_pkg::beat_t pop_beat
);

  localparam int idx_width = $clog2(`RM_FIFO_DEPTH);

  axi_read_pkg::beat_t  mem [`RM_FIFO_DEPTH];
  // Extra top bit tells full from empty
  logic [idx_width:0]   wr_ptr;
  logic [idx_width:0]   rd_ptr;
  logic                 head_valid_r;
  axi_read_pkg::beat_t  head_r;
  logic                 empty;
  logic                 pop;
  logic                 load_head;

  assign empty     = (wr_ptr == rd_ptr);
  assign pop       = head_valid_r & pop_ready;
  // Refill the head when it is free or leaving this cycle
  assign load_head = !empty && (!head_valid_r || pop);

  // Write side
  always_ff @(posedge aclk) begin
    if (push)
      mem[wr_ptr[idx_width-1:0]] <= push_beat;
  end

  always_ff @(posedge aclk) begin
    if (areset)
      wr_ptr <= '0;
    else if (push)
      wr_ptr <= wr_ptr + 1'b1;
  end

  // Read side and head register
  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_ptr       <= '0;
      head_valid_r <= 1'b0;
    end else if (load_head) begin
      rd_ptr       <= rd_ptr + 1'b1;
      head_valid_r <= 1'b1;
    end else if (pop) begin
      head_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_head)
      head_r <= mem[rd_ptr[idx_width-1:0]];
  end

  assign pop_valid = head_valid_r;
  assign pop_beat  = head_r;

endmodule

// ==== hdl/read_master_top.sv ====
////////////////////////////////////////
// Burst read master
// Memory-mapped reads out as a beat stream
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module read_master_top (
  input  logic                           aclk,
  input  logic                           areset,
  // Job control
  input  logic                           ctrl_start,
  output logic                           ctrl_done,
  input  axi_read_pkg::addr_t            ctrl_addr_offset,
  input  logic [`RM_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  // Read-address channel
  output logic                           m_axi_arvalid,
  input  logic                           m_axi_arready,
  output axi_read_pkg::addr_t            m_axi_araddr,
  output axi_read_pkg::arlen_t           m_axi_arlen,
  // Read-data channel
  input  logic                           m_axi_rvalid,
  output logic                           m_axi_rready,
  input  axi_read_pkg::data_t            m_axi_rdata,
  input  logic                           m_axi_rlast,
  // Stream out
  output logic                           m_axis_tvalid,
  input  logic                           m_axis_tready,
  output axi_read_pkg::data_t            m_axis_tdata,
  output logic                           m_axis_tlast
);

  read_job_if job ();

  axi_read_pkg::beat_t r_beat;
  axi_read_pkg::beat_t s_beat;
  logic                credit_return;

  // FIFO always has room, so read data is never stalled
  assign m_axi_rready  = 1'b1;
  assign r_beat        = '{data: m_axi_rdata, last: m_axi_rlast};
  assign m_axis_tdata  = s_beat.data;
  assign m_axis_tlast  = s_beat.last;
  // A burst frees its slot once its last beat leaves on the stream
  assign credit_return = m_axis_tvalid & m_axis_tready & m_axis_tlast;

  read_request_regs u_request (
    .aclk (aclk), .areset (areset), .start (ctrl_start),
    .addr_offset (ctrl_addr_offset), .xfer_size (ctrl_xfer_size_in_bytes),
    .job (job.producer)
  );

  ar_issue u_ar_issue (
    .aclk (aclk), .areset (areset), .job (job.issuer),
    .credit_return (credit_return),
    .arvalid (m_axi_arvalid), .arready (m_axi_arready),
    .araddr (m_axi_araddr), .arlen (m_axi_arlen)
  );

  r_tracker u_r_tracker (
    .aclk (aclk), .areset (areset), .job (job.tracker),
    .rvalid (m_axi_rvalid), .rlast (m_axi_rlast), .done (ctrl_done)
  );

  // Pushes straight from rvalid since ready is tied high
  beat_fifo u_fifo (
    .aclk (aclk), .areset (areset),
    .push (m_axi_rvalid), .push_beat (r_beat),
    .pop_ready (m_axis_tready), .pop_valid (m_axis_tvalid), .pop_beat (s_beat)
  );

endmodule

// ==== verif/axi_mem_model.sv ====
////////////////////////////////////////
// Read-only memory model
// Data of each beat is its own byte address
////////////////////////////////////////
`timescale 1ns/1ps

module axi_mem_model (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 arvalid,
  output logic                 arready,
  input  axi_read_pkg::addr_t  araddr,
  input  axi_read_pkg::arlen_t arlen,
  output logic                 rvalid,
  input  logic                 rready,
  output axi_read_pkg::data_t  rdata,
  output logic                 rlast,
  // Random stalls, drawn by the testbench
  input  logic                 ar_stall,
  input  logic                 r_gap
);

  axi_read_pkg::addr_t  addr_q [$];
  axi_read_pkg::arlen_t len_q [$];
  axi_read_pkg::addr_t  beat_addr;
  int                   beats_left;
  logic                 r_taken;

  initial begin
    arready    = 1'b0;
    rvalid     = 1'b0;
    rdata      = '0;
    rlast      = 1'b0;
    r_taken    = 1'b0;
    beat_addr  = '0;
    beats_left = 0;
  end

  // Accepted requests and beats, seen at the rising edge
  always @(posedge aclk) begin
    r_taken <= rvalid && rready;
    if (!areset && arvalid && arready) begin
      addr_q.push_back(araddr);
      len_q.push_back(arlen);
    end
  end

  // Outputs change on the falling edge
  always @(negedge aclk) begin
    if (areset) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      rlast      <= 1'b0;
      beats_left = 0;
      addr_q.delete();
      len_q.delete();
    end else begin
      arready <= !ar_stall;
      // Step past the beat taken at the last edge
      if (r_taken) begin
        beats_left = beats_left - 1;
        beat_addr  = beat_addr + 4;
      end
      // Next queued burst
      if (beats_left == 0 && addr_q.size() > 0) begin
        beat_addr  = addr_q.pop_front();
        beats_left = int'(len_q.pop_front()) + 1;
      end
      // A beat still waiting keeps its valid
      if (beats_left > 0 && (!r_gap || (rvalid && !r_taken))) begin
        rvalid <= 1'b1;
        rdata  <= beat_addr;
        rlast  <= (beats_left == 1);
      end else begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
      end
    end
  end

endmodule

// ==== verif/tb_read_master.sv ====
////////////////////////////////////////
// Read master testbench
// Directed and random jobs against a reference
////////////////////////////////////////
`timescale 1ns/1ps
`include "read_master_defs.svh"

module tb_read_master;

  localparam int burst_bytes = `RM_BURST_BEATS * `RM_DATA_WIDTH / 8;
  localparam int word_bytes  = `RM_DATA_WIDTH / 8;
  localparam int num_random  = 6;

  logic                           aclk = 1'b0;
  logic                           areset;
  logic                           ctrl_start;
  logic                           ctrl_done;
  axi_read_pkg::addr_t            ctrl_addr_offset;
  logic [`RM_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes;
  logic                           m_axi_arvalid;
  logic                           m_axi_arready;
  axi_read_pkg::addr_t            m_axi_araddr;
  axi_read_pkg::arlen_t           m_axi_arlen;
  logic                           m_axi_rvalid;
  logic                           m_axi_rready;
  axi_read_pkg::data_t            m_axi_rdata;
  logic                           m_axi_rlast;
  logic                           m_axis_tvalid;
  logic                           m_axis_tready = 1'b1;
  axi_read_pkg::data_t            m_axis_tdata;
  logic                           m_axis_tlast;
  logic                           ar_stall = 1'b0;
  logic                           r_gap = 1'b0;

  // Reference queues, {data, last} and {addr, len}
  logic [32:0]          exp_beats [$];
  logic [39:0]          exp_reqs [$];
  axi_read_pkg::data_t  exp_tdata;
  logic                 exp_tlast;
  axi_read_pkg::addr_t  exp_araddr;
  axi_read_pkg::arlen_t exp_arlen;
  int                   exp_pending;
  int                   exp_ar_pending;
  int                   exp_bursts;
  int                   rlast_count;
  int                   in_flight;
  int                   done_count;
  int                   jobs_started;
  int                   errors;
  logic                 job_active;
  logic                 job_done_seen;
  logic                 started;
  logic                 stress = 1'b0;
  logic [31:0]          rng_state = 32'h260c;
  longint               limit_ns;
  logic [31:0]          job_addr [num_random];
  logic [31:0]          job_bytes [num_random];

  always #50 aclk = ~aclk;

  read_master_top UUT (.*);

  axi_mem_model u_mem (
    .aclk (aclk), .areset (areset),
    .arvalid (m_axi_arvalid), .arready (m_axi_arready),
    .araddr (m_axi_araddr), .arlen (m_axi_arlen),
    .rvalid (m_axi_rvalid), .rready (m_axi_rready),
    .rdata (m_axi_rdata), .rlast (m_axi_rlast),
    .ar_stall (ar_stall), .r_gap (r_gap)
  );

  ////////////////////////////////////////
  // Random numbers and reporting
  ////////////////////////////////////////
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // True with a chance of pct in 100
  function automatic logic coin(input int pct);
    return (next_random() % 100) < pct;
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input int num, input string name, input int err_mark);
    if (errors == err_mark)
      $display("test %0d %s: pass", num, name);
    else
      $display("test %0d %s: fail, %0d errors", num, name, errors - err_mark);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic void refresh_heads();
    exp_pending    = exp_beats.size();
    exp_ar_pending = exp_reqs.size();
    if (exp_pending > 0)
      {exp_tdata, exp_tlast} = exp_beats[0];
    if (exp_ar_pending > 0)
      {exp_araddr, exp_arlen} = exp_reqs[0];
  endfunction

  task automatic expect_job(input logic [31:0] addr, input logic [31:0] bytes);
    logic [31:0]          base;
    logic                 is_last;
    axi_read_pkg::arlen_t len;
    int                   words;
    int                   i;
    base  = addr & ~32'(burst_bytes - 1);
    // Partial word rounds up
    words = (bytes + word_bytes - 1) / word_bytes;
    exp_bursts = (words + `RM_BURST_BEATS - 1) / `RM_BURST_BEATS;
    for (i = 0; i < words; i++) begin
      is_last = (i % `RM_BURST_BEATS == `RM_BURST_BEATS - 1) || (i == words - 1);
      exp_beats.push_back({base + 32'(word_bytes * i), is_last});
    end
    for (i = 0; i < exp_bursts; i++) begin
      len = (i == exp_bursts - 1) ? 8'((words - 1) % `RM_BURST_BEATS)
                                  : 8'(`RM_BURST_BEATS - 1);
      exp_reqs.push_back({base + 32'(burst_bytes * i), len});
    end
    rlast_count = 0;
    refresh_heads();
  endtask

  // Bus activity at each rising edge
  always @(posedge aclk) begin
    if (!areset) begin
      if (m_axi_arvalid && m_axi_arready) begin
        in_flight++;
        if (exp_reqs.size() > 0)
          exp_reqs.delete(0);
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (m_axis_tlast)
          in_flight--;
        if (exp_beats.size() > 0)
          exp_beats.delete(0);
      end
      if (m_axi_rvalid && m_axi_rready && m_axi_rlast)
        rlast_count++;
      if (ctrl_done) begin
        done_count++;
        job_done_seen = 1'b1;
      end
      refresh_heads();
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_idle: assert property (@(posedge aclk) disable iff (areset)
    !started |-> !m_axi_arvalid && !ctrl_done && !m_axis_tvalid)
    else flag_mismatch("output active before any start");
  a_rready: assert property (@(posedge aclk) disable iff (areset) m_axi_rready)
    else flag_mismatch("rready low");
  a_ar_req: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && m_axi_arready |->
      exp_ar_pending > 0 && m_axi_araddr == exp_araddr && m_axi_arlen == exp_arlen)
    else flag_mismatch("read request differs from reference");
  a_ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else flag_mismatch("read request changed while stalled");
  a_in_flight: assert property (@(posedge aclk) disable iff (areset)
    in_flight <= `RM_MAX_OUTSTANDING)
    else flag_mismatch("too many bursts outstanding");
  a_stream: assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && m_axis_tready |->
      exp_pending > 0 && m_axis_tdata == exp_tdata && m_axis_tlast == exp_tlast)
    else flag_mismatch("stream beat differs from reference");
  a_done_job: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |-> job_active && rlast_count == exp_bursts)
    else flag_mismatch("ctrl_done outside a job or before final rlast");
  a_done_pulse: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else flag_mismatch("ctrl_done longer than one cycle");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  // Stall pattern, updated after the falling edge
  always @(negedge aclk) begin
    if (stress) begin
      m_axis_tready <= coin(60);
      ar_stall      <= coin(40);
      r_gap         <= coin(30);
    end else begin
      m_axis_tready <= 1'b1;
      ar_stall      <= 1'b0;
      r_gap         <= 1'b0;
    end
  end

  // Starts one job and waits for done and a drained stream
  task automatic run_job(input logic [31:0] addr, input logic [31:0] bytes);
    expect_job(addr, bytes);
    job_done_seen           = 1'b0;
    job_active              = 1'b1;
    started                 = 1'b1;
    jobs_started++;
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = bytes;
    ctrl_start              = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    while (!(job_done_seen && exp_pending == 0))
      @(negedge aclk);
    job_active = 1'b0;
    repeat (2) @(negedge aclk);
    assert (done_count == jobs_started)
      else flag_mismatch("ctrl_done count differs from jobs started");
  endtask

  initial begin
    int total_words;
    int i;
    int err_mark;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    job_active              = 1'b0;
    job_done_seen           = 1'b0;
    started                 = 1'b0;
    // Random jobs drawn up front, their words size the watchdog
    total_words = 3 + 50;
    for (i = 0; i < num_random; i++) begin
      job_addr[i]  = next_random() & 32'h0003_ffff;
      job_bytes[i] = 1 + next_random() % 400;
      total_words += (job_bytes[i] + word_bytes - 1) / word_bytes;
    end
    limit_ns = longint'(total_words * 30 + (num_random + 2) * 80 + 40) * 100;
    repeat (16) @(negedge aclk);
    areset = 1'b0;

    err_mark = errors;
    repeat (8) @(negedge aclk);
    report_test(1, "idle after reset", err_mark);

    err_mark = errors;
    run_job(32'h0000_1000, 32'd10);
    report_test(2, "single short burst", err_mark);

    err_mark = errors;
    run_job(32'h0000_2034, 32'd200);
    report_test(3, "unaligned four bursts", err_mark);

    // Random back-pressure and memory stalls
    err_mark = errors;
    stress <= 1'b1;
    for (i = 0; i < num_random; i++)
      run_job(job_addr[i], job_bytes[i]);
    stress <= 1'b0;
    report_test(4, "random jobs under stalls", err_mark);

    err_mark = errors;
    repeat (4) @(negedge aclk);
    assert (done_count == num_random + 2)
      else flag_mismatch("total ctrl_done pulses differ from job count");
    report_test(5, "one done per job", err_mark);

    $display("tests 5, errors %0d", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/axi_read_pkg.sv
hdl/xfer_pkg.sv
hdl/read_job_if.sv
hdl/read_request_regs.sv
hdl/burst_counter.sv
hdl/ar_issue.sv
hdl/r_tracker.sv
hdl/beat_fifo.sv
hdl/read_master_top.sv
verif/axi_mem_model.sv
verif/tb_read_master.sv
